// ==== bus_fabric.sv ====
`timescale 1ns/1ps

module bus_fabric (
    input  logic                    clk_i,
    input  logic                    rv_rst_ni,
    input  soc_mem_pkg::bus_req_t   bus_req_i,
    output soc_mem_pkg::bus_req_t   imem_req_o,
    output soc_mem_pkg::bus_req_t   dmem_req_o,
    input  soc_mem_pkg::word_t      imem_rd_i,
    input  soc_mem_pkg::word_t      dmem_rd_i,
    output soc_mem_pkg::word_t      rd_data_o,
    output soc_mem_pkg::addr_t      pim_addr_o,
    output soc_mem_pkg::word_t      pim_wr_o,
    input  soc_mem_pkg::word_t      pim_rd_i
);

    soc_mem_pkg::region_e req_region;
    soc_mem_pkg::region_e rd_region_q;
    logic                 rd_pending_q;
    logic                 pim_access;
    soc_mem_pkg::word_t   pim_rd_q;
    soc_mem_pkg::word_t   rd_sel;
    soc_mem_pkg::word_t   rd_hold_q;

    // Top nibble picks the target
    always_comb begin
        case (bus_req_i.addr[soc_mem_pkg::XLEN-1 -: 4])
            soc_mem_pkg::IMEM_REGION: req_region = soc_mem_pkg::REGION_IMEM;
            soc_mem_pkg::DMEM_REGION: req_region = soc_mem_pkg::REGION_DMEM;
            soc_mem_pkg::PIM_REGION:  req_region = soc_mem_pkg::REGION_PIM;
            default:                  req_region = soc_mem_pkg::REGION_NONE;
        endcase
    end

    // Address and data fan out, strobes only reach the decoded memory
    always_comb begin
        imem_req_o       = bus_req_i;
        imem_req_o.read  = bus_req_i.read  && (req_region == soc_mem_pkg::REGION_IMEM);
        imem_req_o.write = bus_req_i.write && (req_region == soc_mem_pkg::REGION_IMEM);

        dmem_req_o       = bus_req_i;
        dmem_req_o.read  = bus_req_i.read  && (req_region == soc_mem_pkg::REGION_DMEM);
        dmem_req_o.write = bus_req_i.write && (req_region == soc_mem_pkg::REGION_DMEM);
    end

    assign pim_access = (req_region == soc_mem_pkg::REGION_PIM)
                        && (bus_req_i.read || bus_req_i.write);

    // PIM controller outputs
    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            pim_addr_o <= '0;
            pim_wr_o   <= '0;
        end else if (pim_access) begin
            pim_addr_o <= bus_req_i.addr;
            if (bus_req_i.write) begin
                pim_wr_o <= bus_req_i.wr_data;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (pim_access && bus_req_i.read) begin
            pim_rd_q <= pim_rd_i;
        end
    end

    // Region of the read in flight, plus the last returned word
    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            rd_region_q  <= soc_mem_pkg::REGION_NONE;
            rd_pending_q <= 1'b0;
            rd_hold_q    <= '0;
        end else begin
            rd_pending_q <= bus_req_i.read;
            rd_hold_q    <= rd_data_o;
            if (bus_req_i.read) begin
                rd_region_q <= req_region;
            end
        end
    end

    always_comb begin
        case (rd_region_q)
            soc_mem_pkg::REGION_IMEM: rd_sel = imem_rd_i;
            soc_mem_pkg::REGION_DMEM: rd_sel = dmem_rd_i;
            soc_mem_pkg::REGION_PIM:  rd_sel = pim_rd_q;
            default:                  rd_sel = '0;
        endcase
    end

    // imem banks read every cycle, so the word is held here between reads
    assign rd_data_o = rd_pending_q ? rd_sel : rd_hold_q;

endmodule

// ==== byte_bank_ram.sv ====
`timescale 1ns/1ps

module byte_bank_ram #(
    parameter int MEM_ADDR_WIDTH = soc_mem_pkg::DEFAULT_WORD_ADDR_W
) (
    input  logic                      clk_i,
    input  logic [MEM_ADDR_WIDTH-1:0] addr_i,
    input  logic                      wr_en_i,
    input  soc_mem_pkg::byte_t        wr_data_i,
    output soc_mem_pkg::byte_t        rd_data_o
);

    localparam int DEPTH = 2 ** MEM_ADDR_WIDTH;

    soc_mem_pkg::byte_t mem [DEPTH];

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem[addr_i] <= wr_data_i;
        end
    end

    // Read port samples the address on every edge, like the hard macro
    always_ff @(posedge clk_i) begin
        rd_data_o <= mem[addr_i];
    end

endmodule

// ==== dmem_word.sv ====
`timescale 1ns/1ps

module dmem_word #(
    parameter int MEM_ADDR_WIDTH = soc_mem_pkg::DEFAULT_WORD_ADDR_W
) (
    input  logic                    clk_i,
    input  soc_mem_pkg::bus_req_t   req_i,
    output soc_mem_pkg::word_t      rd_data_o
);

    localparam int DEPTH     = 2 ** MEM_ADDR_WIDTH;
    localparam int NUM_LANES = soc_mem_pkg::XLEN / 8;

    soc_mem_pkg::word_t          mem [DEPTH];
    logic [MEM_ADDR_WIDTH-1:0]   word_idx;
    soc_mem_pkg::byte_en_t       lane_we;

    // Low two address bits select nothing here
    assign word_idx = req_i.addr[MEM_ADDR_WIDTH+1:2];
    assign lane_we  = req_i.byte_en & {NUM_LANES{req_i.write}};

    // Merge only the enabled lanes
    always_ff @(posedge clk_i) begin
        for (int k = 0; k < NUM_LANES; k++) begin
            if (lane_we[k]) begin
                mem[word_idx][8*k +: 8] <= req_i.wr_data[8*k +: 8];
            end
        end
    end

    // Output holds its value between reads
    always_ff @(posedge clk_i) begin
        if (req_i.read) begin
            rd_data_o <= mem[word_idx];
        end
    end

endmodule

// ==== flist.f ====
+incdir+.
soc_mem_pkg.sv
byte_bank_ram.sv
imem_unaligned.sv
dmem_word.sv
bus_fabric.sv
soc_mem_top.sv
tb_soc_mem.sv

// ==== imem_unaligned.sv ====
`timescale 1ns/1ps

module imem_unaligned #(
    parameter int MEM_ADDR_WIDTH = soc_mem_pkg::DEFAULT_WORD_ADDR_W
) (
    input  logic                    clk_i,
    input  logic                    rv_rst_ni,
    input  soc_mem_pkg::bus_req_t   req_i,
    output soc_mem_pkg::word_t      rd_data_o
);

    localparam int NUM_BANKS = soc_mem_pkg::XLEN / 8;

    typedef logic [MEM_ADDR_WIDTH-1:0] word_idx_t;

    word_idx_t          word_idx;
    logic [1:0]         offset;
    logic [1:0]         offset_q;
    word_idx_t          bank_addr [NUM_BANKS];
    logic               bank_we   [NUM_BANKS];
    soc_mem_pkg::byte_t bank_rd   [NUM_BANKS];

    assign word_idx = req_i.addr[MEM_ADDR_WIDTH+1:2];
    assign offset   = req_i.addr[1:0];

    // Bank k holds byte lane k of every word
    for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
        // Banks below the offset already belong to the next word
        assign bank_addr[k] = word_idx + word_idx_t'(offset > 2'(k));
        assign bank_we[k]   = req_i.write & req_i.byte_en[k];

        byte_bank_ram #(
            .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
        ) u_bank (
            .clk_i          (clk_i),
            .addr_i         (bank_addr[k]),
            .wr_en_i        (bank_we[k]),
            .wr_data_i      (req_i.wr_data[8*k +: 8]),
            .rd_data_o      (bank_rd[k])
        );
    end

    // Offset follows the bank read by one cycle
    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            offset_q <= '0;
        end else begin
            offset_q <= offset;
        end
    end

    // Byte at the requested address goes to lane 0
    always_comb begin
        for (int j = 0; j < NUM_BANKS; j++) begin
            rd_data_o[8*j +: 8] = bank_rd[2'(2'(j) + offset_q)];
        end
    end

endmodule

// ==== soc_mem_pkg.sv ====
package soc_mem_pkg;

    // Bus data and address width
    localparam int XLEN = 32;

    // Word-index width of each memory unless the top level overrides it
    localparam int DEFAULT_WORD_ADDR_W = 12;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [XLEN-1:0]   addr_t;
    typedef logic [7:0]        byte_t;

    // Bit k enables lane k
    typedef logic [XLEN/8-1:0] byte_en_t;

    // Decoded bus target
    typedef enum logic [1:0] {
        REGION_NONE,
        REGION_IMEM,
        REGION_DMEM,
        REGION_PIM
    } region_e;

    // Compared with address bits 31 to 28
    localparam logic [3:0] IMEM_REGION = 4'h1;
    localparam logic [3:0] DMEM_REGION = 4'h2;
    localparam logic [3:0] PIM_REGION  = 4'h4;

    // One bus request, strobes are single cycle
    typedef struct packed {
        addr_t    addr;
        word_t    wr_data;
        byte_en_t byte_en;
        logic     read;
        logic     write;
    } bus_req_t;

endpackage

// ==== soc_mem_top.sv ====
`timescale 1ns/1ps

module soc_mem_top #(
    parameter int MEM_ADDR_WIDTH = soc_mem_pkg::DEFAULT_WORD_ADDR_W
) (
    input  logic                    clk_i,
    input  logic                    rv_rst_ni,

    // Bus port
    input  soc_mem_pkg::bus_req_t   bus_req_i,
    output soc_mem_pkg::word_t      rd_data_o,

    // PIM controller
    output soc_mem_pkg::addr_t      pim_addr_o,
    output soc_mem_pkg::word_t      pim_wr_o,
    input  soc_mem_pkg::word_t      pim_rd_i
);

    soc_mem_pkg::bus_req_t imem_req;
    soc_mem_pkg::bus_req_t dmem_req;
    soc_mem_pkg::word_t    imem_rd;
    soc_mem_pkg::word_t    dmem_rd;

    bus_fabric u_fabric (
        .clk_i          (clk_i),
        .rv_rst_ni      (rv_rst_ni),
        .bus_req_i      (bus_req_i),
        .imem_req_o     (imem_req),
        .dmem_req_o     (dmem_req),
        .imem_rd_i      (imem_rd),
        .dmem_rd_i      (dmem_rd),
        .rd_data_o      (rd_data_o),
        .pim_addr_o     (pim_addr_o),
        .pim_wr_o       (pim_wr_o),
        .pim_rd_i       (pim_rd_i)
    );

    // Instruction memory, byte banked
    imem_unaligned #(
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) u_imem (
        .clk_i          (clk_i),
        .rv_rst_ni      (rv_rst_ni),
        .req_i          (imem_req),
        .rd_data_o      (imem_rd)
    );

    // Data memory
    dmem_word #(
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) u_dmem (
        .clk_i          (clk_i),
        .req_i          (dmem_req),
        .rd_data_o      (dmem_rd)
    );

endmodule

// ==== tb_soc_mem_tasks.svh ====
`ifndef TB_SOC_MEM_TASKS_SVH
`define TB_SOC_MEM_TASKS_SVH

function automatic soc_mem_pkg::addr_t make_addr(input logic [3:0] region,
                                                 input int unsigned byte_off);
    return {region, 28'(byte_off)};
endfunction

// Bytes A to A+3 from the model, lane 0 first
function automatic soc_mem_pkg::word_t imem_expect(input int unsigned byte_addr);
    soc_mem_pkg::word_t w;
    for (int k = 0; k < 4; k++) begin
        w[8*k +: 8] = imem_model[(byte_addr + k) % IMEM_BYTES];
    end
    return w;
endfunction

task automatic check_word(input soc_mem_pkg::word_t got, input soc_mem_pkg::word_t exp,
                          input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_addr(input soc_mem_pkg::addr_t got, input soc_mem_pkg::addr_t exp,
                          input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic bus_write(input soc_mem_pkg::addr_t addr, input soc_mem_pkg::word_t data,
                         input soc_mem_pkg::byte_en_t be);
    @(negedge clk_i);
    bus_req.addr    = addr;
    bus_req.wr_data = data;
    bus_req.byte_en = be;
    bus_req.read    = 1'b0;
    bus_req.write   = 1'b1;
    @(negedge clk_i);
    bus_req.write   = 1'b0;
endtask

// Data sampled between the edge after the strobe and the next one
task automatic bus_read(input soc_mem_pkg::addr_t addr, output soc_mem_pkg::word_t data);
    @(negedge clk_i);
    bus_req.addr    = addr;
    bus_req.byte_en = '0;
    bus_req.read    = 1'b1;
    bus_req.write   = 1'b0;
    @(negedge clk_i);
    bus_req.read    = 1'b0;
    @(negedge clk_i);
    data = rd_data;
endtask

task automatic test_reset();
    check_word(rd_data, '0, "rd_data_o after reset");
    check_addr(pim_addr, '0, "pim_addr_o after reset");
    check_word(pim_wr, '0, "pim_wr_o after reset");
endtask

task automatic test_dmem_byte_enables();
    soc_mem_pkg::word_t    data;
    soc_mem_pkg::word_t    got;
    soc_mem_pkg::byte_en_t be;
    int unsigned           idx;
    for (int i = 0; i < DMEM_WORDS_USED; i++) begin
        data = $urandom;
        dmem_model[i] = data;
        bus_write(make_addr(soc_mem_pkg::DMEM_REGION, 4 * i), data, '1);
    end
    // Partial writes merge into the stored words
    for (int i = 0; i < 24; i++) begin
        idx  = $urandom_range(DMEM_WORDS_USED - 1);
        data = $urandom;
        be   = soc_mem_pkg::byte_en_t'($urandom);
        for (int k = 0; k < 4; k++) begin
            if (be[k]) begin
                dmem_model[idx][8*k +: 8] = data[8*k +: 8];
            end
        end
        bus_write(make_addr(soc_mem_pkg::DMEM_REGION, 4 * idx), data, be);
    end
    for (int i = 0; i < DMEM_WORDS_USED; i++) begin
        bus_read(make_addr(soc_mem_pkg::DMEM_REGION, 4 * i + $urandom_range(3)), got);
        check_word(got, dmem_model[i], $sformatf("dmem read of word %0d", i));
    end
endtask

task automatic test_imem_unaligned();
    soc_mem_pkg::word_t data;
    soc_mem_pkg::word_t got;
    for (int w = 0; w < IMEM_WORDS_USED; w++) begin
        data = $urandom;
        for (int k = 0; k < 4; k++) begin
            imem_model[4*w + k] = data[8*k +: 8];
        end
        bus_write(make_addr(soc_mem_pkg::IMEM_REGION, 4 * w), data, '1);
    end
    // Every byte offset, crossing word boundaries
    for (int a = 0; a <= 4 * IMEM_WORDS_USED - 4; a++) begin
        bus_read(make_addr(soc_mem_pkg::IMEM_REGION, a), got);
        check_word(got, imem_expect(a), $sformatf("imem read at byte %0d", a));
    end
    // A write with no lanes enabled moves the banks but not the returned word
    bus_write(make_addr(soc_mem_pkg::IMEM_REGION, 0), '0, '0);
    check_word(rd_data, imem_expect(4 * IMEM_WORDS_USED - 4), "imem read data held");
endtask

task automatic test_pim_port();
    soc_mem_pkg::addr_t addr;
    soc_mem_pkg::word_t data;
    soc_mem_pkg::word_t exp;
    soc_mem_pkg::word_t got;
    for (int i = 0; i < 4; i++) begin
        addr = make_addr(soc_mem_pkg::PIM_REGION, $urandom);
        data = $urandom;
        bus_write(addr, data, '1);
        check_addr(pim_addr, addr, "pim_addr_o after PIM write");
        check_word(pim_wr, data, "pim_wr_o after PIM write");

        addr = make_addr(soc_mem_pkg::PIM_REGION, $urandom);
        @(negedge clk_i);
        exp    = $urandom;
        pim_rd = exp;
        bus_read(addr, got);
        check_word(got, exp, "PIM read data");
        check_addr(pim_addr, addr, "pim_addr_o after PIM read");
        check_word(pim_wr, data, "pim_wr_o after PIM read");
        // Returned word was sampled at the read edge
        pim_rd = ~exp;
        @(negedge clk_i);
        check_word(rd_data, exp, "PIM read data after pim_rd_i moved");
    end
endtask

task automatic test_unmapped();
    logic [3:0]         regions [3] = '{4'h0, 4'h3, 4'h8};
    soc_mem_pkg::addr_t saved_addr;
    soc_mem_pkg::word_t saved_wr;
    soc_mem_pkg::word_t got;
    saved_addr = pim_addr;
    saved_wr   = pim_wr;
    for (int r = 0; r < 3; r++) begin
        // Low bits alias word 4 of both memories
        bus_write(make_addr(regions[r], 16), $urandom, '1);
        check_addr(pim_addr, saved_addr, "pim_addr_o after unmapped write");
        check_word(pim_wr, saved_wr, "pim_wr_o after unmapped write");
        bus_read(make_addr(soc_mem_pkg::DMEM_REGION, 16), got);
        check_word(got, dmem_model[4], "dmem word after unmapped write");
        bus_read(make_addr(soc_mem_pkg::IMEM_REGION, 16), got);
        check_word(got, imem_expect(16), "imem word after unmapped write");
        bus_read(make_addr(regions[r], 16), got);
        check_word(got, '0, "unmapped read");
    end
endtask

task automatic test_back_to_back();
    soc_mem_pkg::word_t exp_q [$];
    int unsigned        off;
    for (int i = 0; i <= B2B_READS; i++) begin
        @(negedge clk_i);
        // Read i-1 has its data on the bus now
        if (i >= 1) begin
            check_word(rd_data, exp_q.pop_front(), $sformatf("back-to-back read %0d", i - 1));
        end
        if (i >= B2B_READS) begin
            bus_req.read = 1'b0;
        end else begin
            bus_req.read    = 1'b1;
            bus_req.write   = 1'b0;
            bus_req.byte_en = '0;
            case (i % 3)
                0: begin
                    off = $urandom_range(4 * IMEM_WORDS_USED - 4);
                    bus_req.addr = make_addr(soc_mem_pkg::IMEM_REGION, off);
                    exp_q.push_back(imem_expect(off));
                end
                1: begin
                    off = $urandom_range(DMEM_WORDS_USED - 1);
                    bus_req.addr = make_addr(soc_mem_pkg::DMEM_REGION,
                                             4 * off + $urandom_range(3));
                    exp_q.push_back(dmem_model[off]);
                end
                default: begin
                    pim_rd       = $urandom;
                    bus_req.addr = make_addr(soc_mem_pkg::PIM_REGION, $urandom);
                    exp_q.push_back(pim_rd);
                end
            endcase
        end
    end
endtask

`endif

// ==== tb_soc_mem.sv ====
`timescale 1ns/1ps

module tb_soc_mem;

    localparam int MEM_AW          = 6;
    localparam int MEM_WORDS       = 2 ** MEM_AW;
    localparam int IMEM_BYTES      = 4 * MEM_WORDS;
    localparam int DMEM_WORDS_USED = 16;
    localparam int IMEM_WORDS_USED = 8;
    localparam int B2B_READS       = 15;
    localparam int TIMEOUT_CYCLES  = 3000;
    localparam int SEED            = 38261;

    logic                  clk_i;
    logic                  rv_rst_ni;
    soc_mem_pkg::bus_req_t bus_req;
    soc_mem_pkg::word_t    rd_data;
    soc_mem_pkg::addr_t    pim_addr;
    soc_mem_pkg::word_t    pim_wr;
    soc_mem_pkg::word_t    pim_rd;

    // Reference models
    soc_mem_pkg::byte_t    imem_model [IMEM_BYTES];
    soc_mem_pkg::word_t    dmem_model [MEM_WORDS];

    int                    check_count;
    int                    error_count;
    int                    cycle_count;

    soc_mem_top #(
        .MEM_ADDR_WIDTH (MEM_AW)
    ) dut0 (
        .clk_i          (clk_i),
        .rv_rst_ni      (rv_rst_ni),
        .bus_req_i      (bus_req),
        .rd_data_o      (rd_data),
        .pim_addr_o     (pim_addr),
        .pim_wr_o       (pim_wr),
        .pim_rd_i       (pim_rd)
    );

    `include "tb_soc_mem_tasks.svh"

    initial begin
        clk_i = 1'b0;
        forever begin
            #20 clk_i = ~clk_i;
        end
    end

    // Run limit
    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d clock cycles",
                     TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(SEED));
        check_count = 0;
        error_count = 0;
        bus_req     = '0;
        pim_rd      = '0;
        rv_rst_ni   = 1'b0;

        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rv_rst_ni = 1'b1;

        test_reset();
        test_dmem_byte_enables();
        test_imem_unaligned();
        test_pim_port();
        test_unmapped();
        test_back_to_back();

        repeat (2) @(negedge clk_i);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
